/* filelist.f */
+incdir+.
eval_pkg.sv
board_scan.sv
taper_blend.sv
eval_control.sv
evaluate_top.sv
tb_evaluate.sv

/* run_sim.sh */
#!/bin/sh
# Build the board evaluator testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
   -f filelist.f --top-module tb_evaluate -o sim_evaluate

./obj_dir/sim_evaluate > sim.log 2>&1
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log
then
   echo "run_sim: testbench reported failure"
   exit 1
fi
echo "run_sim: testbench passed"

/* tb_eval_model.svh */
// Reference model for the board evaluator testbench
// Expected material and tapered score of a packed board
`ifndef TB_EVAL_MODEL_SVH
`define TB_EVAL_MODEL_SVH

// Middlegame value by type code
function automatic longint mg_piece(input logic [2:0] ptype);
   case (ptype)
      3'd1:    return 100;
      3'd2:    return 305;
      3'd3:    return 333;
      3'd4:    return 500;
      3'd5:    return 950;
      default: return 0;   // Empty, king, unused
   endcase
endfunction

// Endgame value by type code
function automatic longint eg_piece(input logic [2:0] ptype);
   case (ptype)
      3'd1:    return 120;
      3'd2:    return 290;
      3'd3:    return 320;
      3'd4:    return 540;
      3'd5:    return 1000;
      default: return 0;
   endcase
endfunction

task automatic compute_expected
(
   input  logic [255:0] b,
   output logic [15:0]  exp_eval,
   output logic [15:0]  exp_white,
   output logic [15:0]  exp_black
);
   longint     mg;
   longint     eg;
   longint     white;
   longint     black;
   longint     phase;
   longint     blended;
   longint     score;
   logic [3:0] sq;
   mg    = 0;
   eg    = 0;
   white = 0;
   black = 0;
   phase = 0;
   for (int s = 0; s < 64; s++)
   begin
      sq = b[s*4 +: 4];
      if (sq[3])                          // Black side
      begin
         mg    = mg - mg_piece(sq[2:0]);
         eg    = eg - eg_piece(sq[2:0]);
         black = black + mg_piece(sq[2:0]);
      end
      else
      begin
         mg    = mg + mg_piece(sq[2:0]);
         eg    = eg + eg_piece(sq[2:0]);
         white = white + mg_piece(sq[2:0]);
      end
      if (sq[2:0] != 3'd0 && sq[2:0] != 3'd1)
         phase = phase + 1;
   end
   if (phase > 62)
      phase = 62;                         // Phase cap
   blended   = mg * phase + eg * (62 - phase);
   score     = (blended * 16912) / 1048576; // Integer divide truncates toward zero
   exp_eval  = score[15:0];
   exp_white = white[15:0];
   exp_black = black[15:0];
endtask

`endif

/* tb_evaluate.sv */
// Testbench for the board evaluator
// Start position, material imbalance, random boards and the hold and clear handshake
`timescale 1ns/1ps
`default_nettype none

module tb_evaluate;
   import eval_pkg::*;

   localparam int CLK_PERIOD    = 8;
   localparam int LATENCY       = 16;    // Sampled rise to eval_valid
   localparam int SCAN_EDGES    = 9;     // Sampled rise to scan_done
   localparam int WAIT_LIMIT    = 100;   // Cycles before a wait gives up
   localparam int RANDOM_BOARDS = 30;

   logic      clk;
   logic      reset;
   board_t    board_in;
   logic      board_valid;
   logic      clear_eval;
   eval_t     eval;
   logic      eval_valid;
   material_t material_white;
   material_t material_black;
   int        value_errors;
   int        protocol_errors;

   `include "tb_eval_model.svh"

   evaluate_top i_dut
   (
      .clk            (clk),
      .reset          (reset),
      .board_in       (board_in),
      .board_valid    (board_valid),
      .clear_eval     (clear_eval),
      .eval           (eval),
      .eval_valid     (eval_valid),
      .material_white (material_white),
      .material_black (material_black)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Held result must not move or drop until cleared
   assert property (@(posedge clk) disable iff (reset)
                    (eval_valid && !clear_eval) |=> eval_valid)
   else
   begin
      protocol_errors++;
      $display("eval_valid dropped while clear_eval was low");
   end

   assert property (@(posedge clk) disable iff (reset)
                    (eval_valid && !clear_eval) |=>
                    ($stable(eval) && $stable(material_white) && $stable(material_black)))
   else
   begin
      protocol_errors++;
      $display("Outputs changed while the result was held");
   end

   assert property (@(posedge clk) disable iff (reset)
                    (eval_valid && clear_eval) |=> !eval_valid)
   else
   begin
      protocol_errors++;
      $display("eval_valid stayed high after clear_eval");
   end

   task automatic finish_run();
      $display("Run complete: %0d value errors, %0d protocol errors",
               value_errors, protocol_errors);
      if (value_errors == 0 && protocol_errors == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   endtask

   task automatic check_value(input string label, input string name,
                              input logic [15:0] got, input logic [15:0] exp);
      assert (got == exp)
      else
      begin
         value_errors++;
         $display("Error: %s %s = 0x%0h, expected 0x%0h", label, name, got, exp);
      end
   endtask

   // Count edges after the sampled rise until eval_valid rises, noting scan_done pulses
   task automatic wait_for_valid(output int cycles, output int done_cycle,
                                 output int done_pulses);
      cycles      = 0;
      done_cycle  = 0;
      done_pulses = 0;
      while (!eval_valid && cycles < WAIT_LIMIT)
      begin
         @(posedge clk);
         #1;
         cycles++;
         if (i_dut.scan_done)
         begin
            done_pulses++;
            done_cycle = cycles;
         end
      end
      if (!eval_valid)
      begin
         protocol_errors++;
         $display("Timeout: eval_valid not seen within %0d cycles", WAIT_LIMIT);
         finish_run();
      end
   endtask

   task automatic check_outputs(input board_t b, input string label);
      logic [15:0] exp_eval;
      logic [15:0] exp_white;
      logic [15:0] exp_black;
      compute_expected(b, exp_eval, exp_white, exp_black);
      check_value(label, "eval", eval, exp_eval);
      check_value(label, "material_white", material_white, exp_white);
      check_value(label, "material_black", material_black, exp_black);
   endtask

   // Raise board_valid with a board, leaves the DUT holding its result
   task automatic run_board(input board_t b, input string label);
      int cycles;
      int done_cycle;
      int done_pulses;
      @(posedge clk);
      #1;
      board_in    = b;
      board_valid = 1'b1;
      @(posedge clk);                     // Rise sampled here
      #1;
      wait_for_valid(cycles, done_cycle, done_pulses);
      assert (cycles == LATENCY)
      else
      begin
         protocol_errors++;
         $display("%s: eval_valid came after %0d cycles, not %0d", label, cycles, LATENCY);
      end
      assert (done_pulses == 1 && done_cycle == SCAN_EDGES)
      else
      begin
         protocol_errors++;
         $display("%s: scan_done pulsed %0d times, last after %0d cycles, expected once after %0d",
                  label, done_pulses, done_cycle, SCAN_EDGES);
      end
      check_outputs(b, label);
   endtask

   task automatic clear_result();
      @(posedge clk);
      #1;
      clear_eval = 1'b1;
      @(posedge clk);                     // Clear sampled here
      #1;
      clear_eval = 1'b0;
      assert (!eval_valid)
      else
      begin
         protocol_errors++;
         $display("eval_valid still high one cycle after clear_eval");
      end
   endtask

   task automatic evaluate_board(input board_t b, input string label);
      run_board(b, label);
      board_valid = 1'b0;
      clear_result();
   endtask

   task automatic check_idle(input string label, input int cycles);
      repeat (cycles)
      begin
         @(posedge clk);
         #1;
         assert (!eval_valid)
         else
         begin
            protocol_errors++;
            $display("%s: eval_valid rose with no board_valid rise", label);
         end
      end
   endtask

   function automatic board_t start_board();
      board_t     b;
      logic [2:0] back_rank [8];
      back_rank = '{3'd4, 3'd2, 3'd3, 3'd5, 3'd6, 3'd3, 3'd2, 3'd4};
      b = '0;
      for (int f = 0; f < 8; f++)
      begin
         b[f*4 +: 4]      = {1'b0, back_rank[f]}; // White back rank
         b[(8+f)*4 +: 4]  = 4'h1;                 // White pawns
         b[(48+f)*4 +: 4] = 4'h9;                 // Black pawns
         b[(56+f)*4 +: 4] = {1'b1, back_rank[f]};
      end
      return b;
   endfunction

   function automatic board_t random_board();
      board_t b;
      for (int s = 0; s < 64; s++)
         b[s*4 +: 4] = {1'($urandom), 3'($urandom % 7)};
      return b;
   endfunction

   initial
   begin
      board_t b;
      void'($urandom(32'h390f));
      value_errors    = 0;
      protocol_errors = 0;
      reset           = 1'b1;
      board_in        = '0;
      board_valid     = 1'b0;
      clear_eval      = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      reset = 1'b0;

      check_idle("after reset", 20);

      // Start position is balanced
      run_board(start_board(), "start");
      check_value("start", "eval", eval, 16'h0000);
      // 8 pawns, 2 knights, 2 bishops, 2 rooks and a queen per side
      check_value("start", "material_white", material_white, 16'd4026);
      check_value("start", "material_black", material_black, 16'd4026);
      board_valid = 1'b0;
      clear_result();

      // Imbalanced boards, negatives and the phase cap
      b = start_board();
      b[3*4 +: 4] = 4'h0;                // White queen gone
      evaluate_board(b, "no white queen");
      b = start_board();
      b[56*4 +: 4] = 4'h0;               // Black rook and knight gone
      b[57*4 +: 4] = 4'h0;
      evaluate_board(b, "black down rook");
      b = '0;
      b[4*4 +: 4]  = 4'h6;               // Kings and one black pawn
      b[60*4 +: 4] = 4'he;
      b[52*4 +: 4] = 4'h9;
      evaluate_board(b, "lone pawn");
      b = {64{4'h5}};
      evaluate_board(b, "all queens");

      for (int n = 0; n < RANDOM_BOARDS; n++)
         evaluate_board(random_board(), $sformatf("random %0d", n));

      // Held result ignores new boards and board_valid toggles
      b = random_board();
      run_board(b, "hold");
      repeat (6)
      begin
         @(posedge clk);
         #1;
         board_in    = random_board();
         board_valid = ~board_valid;
      end
      check_outputs(b, "hold after toggles");
      board_valid = 1'b1;                // Held high across the clear
      clear_result();
      check_idle("valid held high", 20);
      @(posedge clk);
      #1;
      board_valid = 1'b0;
      evaluate_board(random_board(), "after new rise");

      finish_run();
   end

endmodule

`default_nettype wire

/* evaluate_top.sv */
// Board evaluator top level
// Control, material scan and tapered blend in a fixed latency chain
`timescale 1ns/1ps
`default_nettype none

module evaluate_top
(
   input  logic                clk,
   input  logic                reset,
   input  eval_pkg::board_t    board_in,
   input  logic                board_valid,
   input  logic                clear_eval,
   output eval_pkg::eval_t     eval,
   output logic                eval_valid,
   output eval_pkg::material_t material_white,
   output eval_pkg::material_t material_black
);
   import eval_pkg::*;

   board_t board;        // Captured board
   logic   scan_start;
   logic   scan_done;    // End of scan marker, control counts the same length
   sum_t   mg_sum;
   sum_t   eg_sum;
   phase_t phase;

   eval_control i_control
   (
      .clk         (clk),
      .reset       (reset),
      .board_valid (board_valid),
      .clear_eval  (clear_eval),
      .board_in    (board_in),
      .board       (board),
      .scan_start  (scan_start),
      .eval_valid  (eval_valid)
   );

   board_scan i_scan
   (
      .clk            (clk),
      .reset          (reset),
      .scan_start     (scan_start),
      .board          (board),
      .mg_sum         (mg_sum),
      .eg_sum         (eg_sum),
      .phase          (phase),
      .material_white (material_white),
      .material_black (material_black),
      .scan_done      (scan_done)
   );

   taper_blend i_blend
   (
      .clk    (clk),
      .mg_sum (mg_sum),
      .eg_sum (eg_sum),
      .phase  (phase),
      .eval   (eval)
   );

endmodule

`default_nettype wire

/* eval_control.sv */
// Evaluator control FSM
// Captures the board on a board_valid rise, times the scan and blend, holds the result
`timescale 1ns/1ps
`default_nettype none

module eval_control
(
   input  logic             clk,
   input  logic             reset,
   input  logic             board_valid,
   input  logic             clear_eval,
   input  eval_pkg::board_t board_in,
   output eval_pkg::board_t board,
   output logic             scan_start,
   output logic             eval_valid
);
   import eval_pkg::*;

   ctrl_state_e state;
   lat_cnt_t    lat_cnt;         // Edges since the captured rise
   logic        board_valid_r;   // Previous board_valid sample
   logic        board_rise;

   assign board_rise = board_valid && !board_valid_r;

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         state         <= IDLE;
         lat_cnt       <= '0;
         scan_start    <= 1'b0;
         eval_valid    <= 1'b0;
         board_valid_r <= 1'b0;
      end
      else
      begin
         board_valid_r <= board_valid;   // Sampled in every state
         scan_start    <= 1'b0;
         case (state)
            IDLE:
            begin
               lat_cnt <= '0;
               if (board_rise)
               begin
                  state      <= SCAN;
                  scan_start <= 1'b1;
               end
            end
            SCAN:
            begin
               lat_cnt <= lat_cnt + lat_cnt_t'(1);
               if (lat_cnt == lat_cnt_t'(RANK_COUNT))      // Last rank added this edge
                  state <= WAIT_LATENCY;
            end
            WAIT_LATENCY:
            begin
               lat_cnt <= lat_cnt + lat_cnt_t'(1);
               if (lat_cnt == lat_cnt_t'(EVAL_LATENCY - 1)) // Blend output has settled
               begin
                  state      <= HOLD;
                  eval_valid <= 1'b1;
               end
            end
            HOLD:
            begin
               if (clear_eval)
               begin
                  state      <= IDLE;
                  eval_valid <= 1'b0;
               end
            end
            default:
               state <= IDLE;
         endcase
      end
   end

   // Board capture at the start of an evaluation
   always_ff @(posedge clk)
   begin
      if (state == IDLE && board_rise)
         board <= board_in;
   end

endmodule

`default_nettype wire

/* taper_blend.sv */
// Tapered blend of middlegame and endgame sums by phase
// Free running six stage pipeline, score = (mg*p + eg*(62-p)) / 62
`timescale 1ns/1ps
`default_nettype none

module taper_blend
(
   input  logic             clk,
   input  eval_pkg::sum_t   mg_sum,
   input  eval_pkg::sum_t   eg_sum,
   input  eval_pkg::phase_t phase,
   output eval_pkg::eval_t  eval
);
   import eval_pkg::*;

   phase_t              eg_phase;   // Endgame weight, MAX_PHASE minus phase
   logic signed [6:0]   mg_weight;  // Weights as positive signed operands
   logic signed [6:0]   eg_weight;
   blend_t              mg_prod_t1; // Stage 1 products
   blend_t              eg_prod_t1;
   blend_t              mg_prod_t2; // Stage 2 register
   blend_t              eg_prod_t2;
   blend_t              score_t3;   // Weighted sum
   blend_t              score_t4;   // Scaled by 2^20/62
   blend_t              score_t5;   // Back to integer

   assign eg_phase  = phase_t'(MAX_PHASE) - phase;
   assign mg_weight = $signed({1'b0, phase});
   assign eg_weight = $signed({1'b0, eg_phase});

   always_ff @(posedge clk)
   begin
      mg_prod_t1 <= mg_sum * mg_weight;
      eg_prod_t1 <= eg_sum * eg_weight;

      mg_prod_t2 <= mg_prod_t1;   // Timing stage ahead of the adder
      eg_prod_t2 <= eg_prod_t1;

      score_t3 <= mg_prod_t2 + eg_prod_t2;

      score_t4 <= score_t3 * blend_t'(TAPER_RECIP);

      // Bias negatives so the shift truncates toward zero
      score_t5 <= (score_t4 + (score_t4[$bits(blend_t)-1] ?
                               blend_t'((1 << TAPER_SHIFT) - 1) : blend_t'(0)))
                  >>> TAPER_SHIFT;

      eval <= score_t5[$bits(eval_t)-1:0]; // Drop upper bits
   end

endmodule

`default_nettype wire

/* board_scan.sv */
// Material scanner, one rank per cycle
// Sums signed piece values per phase of game, per-side material and the phase count
`timescale 1ns/1ps
`default_nettype none

module board_scan
(
   input  logic                clk,
   input  logic                reset,
   input  logic                scan_start,
   input  eval_pkg::board_t    board,
   output eval_pkg::sum_t      mg_sum,
   output eval_pkg::sum_t      eg_sum,
   output eval_pkg::phase_t    phase,
   output eval_pkg::material_t material_white,
   output eval_pkg::material_t material_black,
   output logic                scan_done
);
   import eval_pkg::*;

   logic                  busy;          // Ranks still to add
   rank_idx_t             rank;          // Rank being added this cycle
   count_t                piece_count;   // Phase pieces so far
   logic [RANK_WIDTH-1:0] rank_bits;     // Current rank slice
   piece_t                square;        // Loop temporaries for the decode
   piece_type_e           ptype;
   sum_t                  rank_mg;       // Contribution of the current rank
   sum_t                  rank_eg;
   material_t             rank_white;
   material_t             rank_black;
   count_t                rank_pieces;
   count_t                total_pieces;  // Count including this rank

   assign rank_bits    = board[rank*RANK_WIDTH +: RANK_WIDTH];
   assign total_pieces = piece_count + rank_pieces;

   // Decode the eight squares of the current rank
   always_comb
   begin
      rank_mg     = '0;
      rank_eg     = '0;
      rank_white  = '0;
      rank_black  = '0;
      rank_pieces = '0;
      square      = '0;
      ptype       = EMPTY;
      for (int i = 0; i < RANK_SQUARES; i++)
      begin
         square = rank_bits[i*PIECE_WIDTH +: PIECE_WIDTH];
         ptype  = piece_type_e'(square[2:0]);
         if (ptype != EMPTY)
         begin
            if (square[COLOUR_BIT]) // Black counts against the score
            begin
               rank_mg    = rank_mg - sum_t'(MG_VALUE[ptype]);
               rank_eg    = rank_eg - sum_t'(EG_VALUE[ptype]);
               rank_black = rank_black + MG_VALUE[ptype];
            end
            else
            begin
               rank_mg    = rank_mg + sum_t'(MG_VALUE[ptype]);
               rank_eg    = rank_eg + sum_t'(EG_VALUE[ptype]);
               rank_white = rank_white + MG_VALUE[ptype];
            end
         end
         if (ptype != EMPTY && ptype != PAWN) // Pawns never count toward phase
            rank_pieces = rank_pieces + count_t'(1);
      end
   end

   // Scan sequencing
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy      <= 1'b0;
         rank      <= '0;
         scan_done <= 1'b0;
      end
      else
      begin
         scan_done <= 1'b0;                  // Single cycle pulse
         if (scan_start)
         begin
            busy <= 1'b1;
            rank <= '0;
         end
         else if (busy)
         begin
            rank <= rank + rank_idx_t'(1);
            if (rank == rank_idx_t'(RANK_COUNT - 1))
            begin
               busy      <= 1'b0;
               scan_done <= 1'b1;
            end
         end
      end
   end

   // Accumulators, held between scans
   always_ff @(posedge clk)
   begin
      if (scan_start)
      begin
         mg_sum         <= '0;
         eg_sum         <= '0;
         material_white <= '0;
         material_black <= '0;
         piece_count    <= '0;
      end
      else if (busy)
      begin
         mg_sum         <= mg_sum + rank_mg;
         eg_sum         <= eg_sum + rank_eg;
         material_white <= material_white + rank_white;
         material_black <= material_black + rank_black;
         piece_count    <= total_pieces;
         if (rank == rank_idx_t'(RANK_COUNT - 1)) // Cap on the last rank
            phase <= (total_pieces > count_t'(MAX_PHASE)) ? phase_t'(MAX_PHASE)
                                                         : phase_t'(total_pieces);
      end
   end

endmodule

`default_nettype wire

/* eval_pkg.sv */
// Board evaluator shared definitions
// Board encoding, piece values, datapath widths and pipeline timing
`default_nettype none

package eval_pkg;

   // Board geometry
   localparam int PIECE_WIDTH  = 4;                          // Colour bit plus type
   localparam int COLOUR_BIT   = 3;                          // Set for black
   localparam int SQUARE_COUNT = 64;
   localparam int RANK_SQUARES = 8;
   localparam int RANK_WIDTH   = RANK_SQUARES * PIECE_WIDTH; // One rank slice of the board

   typedef logic [PIECE_WIDTH-1:0] piece_t;                    // One square
   typedef logic [SQUARE_COUNT*PIECE_WIDTH-1:0] board_t;       // Square s at bits 4s+3:4s

   typedef enum logic [2:0]
   {
      EMPTY  = 3'd0,
      PAWN   = 3'd1,
      KNIGHT = 3'd2,
      BISHOP = 3'd3,
      ROOK   = 3'd4,
      QUEEN  = 3'd5,
      KING   = 3'd6
   } piece_type_e;

   // Datapath widths
   typedef logic signed [15:0] eval_t;     // Final score, White positive
   typedef logic signed [19:0] sum_t;      // Middlegame or endgame sum
   typedef logic        [15:0] material_t; // One side's material
   typedef logic        [5:0]  phase_t;    // 0 to MAX_PHASE
   typedef logic signed [39:0] blend_t;    // Taper intermediates
   typedef logic        [6:0]  count_t;    // Up to 64 counted squares

   // Taper constants
   localparam int MAX_PHASE   = 62;                               // Phase cap and divisor
   localparam int TAPER_SHIFT = 20;                               // Fixed point 2^20
   localparam int TAPER_RECIP = (1 << TAPER_SHIFT) / MAX_PHASE;   // 16912

   // Piece values indexed by type code
   localparam material_t MG_VALUE [8] = '{
      16'd0,    // Empty
      16'd100,  // Pawn
      16'd305,  // Knight
      16'd333,  // Bishop
      16'd500,  // Rook
      16'd950,  // Queen
      16'd0,    // King
      16'd0     // Unused code
   };

   localparam material_t EG_VALUE [8] = '{
      16'd0,
      16'd120,
      16'd290,
      16'd320,
      16'd540,
      16'd1000,
      16'd0,
      16'd0
   };

   // Timing
   localparam int RANK_COUNT    = 8;                               // One rank per scan cycle
   localparam int BLEND_LATENCY = 6;                               // Depth of taper_blend
   localparam int EVAL_LATENCY  = RANK_COUNT + BLEND_LATENCY + 2;  // Start cycle and valid flop

   typedef logic [$clog2(RANK_COUNT)-1:0]   rank_idx_t;  // Scan rank counter
   typedef logic [$clog2(EVAL_LATENCY)-1:0] lat_cnt_t;   // Control latency counter

   typedef enum logic [1:0]
   {
      IDLE,
      SCAN,
      WAIT_LATENCY,
      HOLD
   } ctrl_state_e;

endpackage

`default_nettype wire
